// ==== lsu_defines.svh ====
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Bus widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32
`define LSU_STRB_W 4

// Transfer size field, 0 byte, 1 half, 2 word
`define LSU_SIZE_W 3

// Cycles the unit stays not ready after reset
`define LSU_WARMUP_CYCLES 16
`define LSU_WARMUP_CNT_W 5

`endif

// ==== lsu_pkg.sv ====
package lsu_pkg;

    // Memory opcodes seen at the request port
    typedef enum logic [2:0] {
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW
    } mem_op_e;

    // Bus FSM states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_ADDR,
        ST_RD_DATA,
        ST_WR_REQ,
        ST_WR_RESP,
        ST_DONE
    } bus_state_e;

endpackage

// ==== mem_req_if.sv ====
`timescale 1ns/1ps
`include "lsu_defines.svh"

interface mem_req_if;

    lsu_pkg::mem_op_e          op;
    logic [`LSU_ADDR_W-1:0]    addr;
    logic [`LSU_SIZE_W-1:0]    size;
    logic [`LSU_STRB_W-1:0]    wstrb;
    logic [`LSU_DATA_W-1:0]    wdata;
    logic                      is_write;
    logic                      misaligned;

    // Formatter side
    modport fmt (
        output op, addr, size, wstrb, wdata, is_write, misaligned
    );

    // Sampled by the FSM on acceptance only
    modport fsm (
        input op, addr, size, wstrb, wdata, is_write, misaligned
    );

endinterface

// ==== warmup_counter.sv ====
`timescale 1ns/1ps
`include "lsu_defines.svh"

module warmup_counter (
    input  logic Clk,
    input  logic Myreset,
    output logic o_warm
);

    logic [`LSU_WARMUP_CNT_W-1:0] cnt;

    // Saturates once the warm-up length is reached
    assign o_warm = (cnt == `LSU_WARMUP_CYCLES);

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            cnt <= '0;
        end else if (!o_warm) begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// ==== store_align.sv ====
`timescale 1ns/1ps
`include "lsu_defines.svh"

module store_align (
    input  lsu_pkg::mem_op_e        i_op,
    input  logic [`LSU_ADDR_W-1:0]  i_addr,
    input  logic [`LSU_DATA_W-1:0]  i_wdata,
    mem_req_if.fmt                  req
);

    logic [`LSU_SIZE_W-1:0] size;

    assign req.op   = i_op;
    assign req.addr = i_addr;
    assign req.size = size;

    // Halves need bit 0 clear, words need both low bits clear
    assign req.misaligned = ((size == `LSU_SIZE_W'(1)) && i_addr[0]) ||
                            ((size == `LSU_SIZE_W'(2)) && (i_addr[1:0] != 2'b00));

    always_comb begin
        size         = `LSU_SIZE_W'(2);
        req.wstrb    = '0;
        req.wdata    = '0;
        req.is_write = 1'b0;
        case (i_op)
            lsu_pkg::OP_LB, lsu_pkg::OP_LBU: begin
                size = `LSU_SIZE_W'(0);
            end
            lsu_pkg::OP_LH, lsu_pkg::OP_LHU: begin
                size = `LSU_SIZE_W'(1);
            end
            lsu_pkg::OP_SB: begin
                size         = `LSU_SIZE_W'(0);
                req.is_write = 1'b1;
                req.wstrb    = `LSU_STRB_W'(1) << i_addr[1:0];
                req.wdata    = {4{i_wdata[7:0]}};
            end
            lsu_pkg::OP_SH: begin
                size         = `LSU_SIZE_W'(1);
                req.is_write = 1'b1;
                req.wstrb    = i_addr[1] ? 4'b1100 : 4'b0011;
                req.wdata    = {2{i_wdata[15:0]}};
            end
            lsu_pkg::OP_SW: begin
                req.is_write = 1'b1;
                req.wstrb    = 4'b1111;
                req.wdata    = i_wdata;
            end
            default: begin
                size = `LSU_SIZE_W'(2);
            end
        endcase
    end

endmodule

// ==== load_extend.sv ====
`timescale 1ns/1ps
`include "lsu_defines.svh"

module load_extend (
    input  lsu_pkg::mem_op_e        i_op,
    input  logic [1:0]              i_offset,
    input  logic [`LSU_DATA_W-1:0]  i_word,
    output logic [`LSU_DATA_W-1:0]  o_data
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // Lane pick by address offset
    assign byte_lane = i_word[8*i_offset +: 8];
    assign half_lane = i_offset[1] ? i_word[31:16] : i_word[15:0];

    always_comb begin
        case (i_op)
            lsu_pkg::OP_LB: begin
                o_data = {{24{byte_lane[7]}}, byte_lane};
            end
            lsu_pkg::OP_LBU: begin
                o_data = {24'b0, byte_lane};
            end
            lsu_pkg::OP_LH: begin
                o_data = {{16{half_lane[15]}}, half_lane};
            end
            lsu_pkg::OP_LHU: begin
                o_data = {16'b0, half_lane};
            end
            lsu_pkg::OP_LW: begin
                o_data = i_word;
            end
            // Stores return no data
            default: begin
                o_data = '0;
            end
        endcase
    end

endmodule

// ==== bus_fsm.sv ====
`timescale 1ns/1ps
`include "lsu_defines.svh"

module bus_fsm (
    input  logic                    Clk,
    input  logic                    Myreset,
    input  logic                    i_warm,
    input  logic                    i_req_valid,
    mem_req_if.fsm                  req,
    output logic                    o_req_ready,
    output lsu_pkg::mem_op_e        o_op,
    output logic [1:0]              o_offset,
    output logic [`LSU_DATA_W-1:0]  o_raw_word,
    input  logic [`LSU_DATA_W-1:0]  i_load_data,
    output logic                    o_resp_valid,
    output logic [`LSU_DATA_W-1:0]  o_resp_rdata,
    output logic                    o_resp_err,
    output logic [`LSU_ADDR_W-1:0]  o_araddr,
    output logic [`LSU_SIZE_W-1:0]  o_arsize,
    output logic                    o_arvalid,
    input  logic                    i_arready,
    input  logic [`LSU_DATA_W-1:0]  i_rdata,
    input  logic [1:0]              i_rresp,
    input  logic                    i_rvalid,
    output logic                    o_rready,
    output logic [`LSU_ADDR_W-1:0]  o_awaddr,
    output logic [`LSU_SIZE_W-1:0]  o_awsize,
    output logic                    o_awvalid,
    input  logic                    i_awready,
    output logic [`LSU_DATA_W-1:0]  o_wdata,
    output logic [`LSU_STRB_W-1:0]  o_wstrb,
    output logic                    o_wvalid,
    input  logic                    i_wready,
    input  logic [1:0]              i_bresp,
    input  logic                    i_bvalid,
    output logic                    o_bready
);

    lsu_pkg::bus_state_e     state;
    lsu_pkg::mem_op_e        op_q;
    logic [`LSU_ADDR_W-1:0]  addr_q;
    logic [`LSU_SIZE_W-1:0]  size_q;
    logic [`LSU_STRB_W-1:0]  wstrb_q;
    logic [`LSU_DATA_W-1:0]  wdata_q;
    logic [`LSU_DATA_W-1:0]  raw_q;
    logic                    is_write_q;
    logic                    err_q;
    logic                    mis_wait;
    logic                    aw_done;
    logic                    w_done;
    logic                    accept;
    logic                    aw_fire;
    logic                    w_fire;
    logic                    wr_both;

    assign o_req_ready = i_warm && (state == lsu_pkg::ST_IDLE);
    assign accept      = i_req_valid && o_req_ready;

    assign o_arvalid = (state == lsu_pkg::ST_RD_ADDR);
    assign o_rready  = (state == lsu_pkg::ST_RD_DATA);
    assign o_awvalid = (state == lsu_pkg::ST_WR_REQ) && !aw_done;
    assign o_wvalid  = (state == lsu_pkg::ST_WR_REQ) && !w_done;
    assign o_bready  = (state == lsu_pkg::ST_WR_RESP);

    // aw and w may complete in different cycles
    assign aw_fire = o_awvalid && i_awready;
    assign w_fire  = o_wvalid && i_wready;
    assign wr_both = (aw_done || aw_fire) && (w_done || w_fire);

    assign o_araddr = addr_q;
    assign o_arsize = size_q;
    assign o_awaddr = addr_q;
    assign o_awsize = size_q;
    assign o_wdata  = wdata_q;
    assign o_wstrb  = wstrb_q;

    assign o_op       = op_q;
    assign o_offset   = addr_q[1:0];
    assign o_raw_word = raw_q;

    assign o_resp_valid = (state == lsu_pkg::ST_DONE) && !mis_wait;
    assign o_resp_err   = o_resp_valid && err_q;
    assign o_resp_rdata = (o_resp_valid && !is_write_q && !err_q) ? i_load_data : '0;

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            state    <= lsu_pkg::ST_IDLE;
            err_q    <= 1'b0;
            mis_wait <= 1'b0;
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
        end else begin
            case (state)
                lsu_pkg::ST_IDLE: begin
                    if (accept) begin
                        err_q    <= req.misaligned;
                        mis_wait <= req.misaligned;
                        if (req.misaligned) begin
                            state <= lsu_pkg::ST_DONE;
                        end else if (req.is_write) begin
                            state <= lsu_pkg::ST_WR_REQ;
                        end else begin
                            state <= lsu_pkg::ST_RD_ADDR;
                        end
                    end
                end
                lsu_pkg::ST_RD_ADDR: begin
                    if (i_arready) begin
                        state <= lsu_pkg::ST_RD_DATA;
                    end
                end
                lsu_pkg::ST_RD_DATA: begin
                    if (i_rvalid) begin
                        err_q <= i_rresp[1];
                        state <= lsu_pkg::ST_DONE;
                    end
                end
                lsu_pkg::ST_WR_REQ: begin
                    if (wr_both) begin
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        state   <= lsu_pkg::ST_WR_RESP;
                    end else begin
                        if (aw_fire) begin
                            aw_done <= 1'b1;
                        end
                        if (w_fire) begin
                            w_done <= 1'b1;
                        end
                    end
                end
                lsu_pkg::ST_WR_RESP: begin
                    if (i_bvalid) begin
                        err_q <= i_bresp[1];
                        state <= lsu_pkg::ST_DONE;
                    end
                end
                lsu_pkg::ST_DONE: begin
                    // Misaligned response is held back one cycle
                    if (mis_wait) begin
                        mis_wait <= 1'b0;
                    end else begin
                        state <= lsu_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= lsu_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Request payload and read beat
    always_ff @(posedge Clk) begin
        if (accept) begin
            op_q       <= req.op;
            addr_q     <= req.addr;
            size_q     <= req.size;
            wstrb_q    <= req.wstrb;
            wdata_q    <= req.wdata;
            is_write_q <= req.is_write;
        end
        if (o_rready && i_rvalid) begin
            raw_q <= i_rdata;
        end
    end

endmodule

// ==== lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_top (
    input  logic                    Clk,
    input  logic                    Myreset,
    input  logic                    i_req_valid,
    input  lsu_pkg::mem_op_e        i_req_op,
    input  logic [`LSU_ADDR_W-1:0]  i_req_addr,
    input  logic [`LSU_DATA_W-1:0]  i_req_wdata,
    output logic                    o_req_ready,
    output logic                    o_resp_valid,
    output logic [`LSU_DATA_W-1:0]  o_resp_rdata,
    output logic                    o_resp_err,
    output logic [`LSU_ADDR_W-1:0]  o_araddr,
    output logic [`LSU_SIZE_W-1:0]  o_arsize,
    output logic                    o_arvalid,
    input  logic                    i_arready,
    input  logic [`LSU_DATA_W-1:0]  i_rdata,
    input  logic [1:0]              i_rresp,
    input  logic                    i_rvalid,
    output logic                    o_rready,
    output logic [`LSU_ADDR_W-1:0]  o_awaddr,
    output logic [`LSU_SIZE_W-1:0]  o_awsize,
    output logic                    o_awvalid,
    input  logic                    i_awready,
    output logic [`LSU_DATA_W-1:0]  o_wdata,
    output logic [`LSU_STRB_W-1:0]  o_wstrb,
    output logic                    o_wvalid,
    input  logic                    i_wready,
    input  logic [1:0]              i_bresp,
    input  logic                    i_bvalid,
    output logic                    o_bready
);

    logic                    warm;
    lsu_pkg::mem_op_e        ld_op;
    logic [1:0]              ld_offset;
    logic [`LSU_DATA_W-1:0]  ld_raw;
    logic [`LSU_DATA_W-1:0]  ld_data;

    mem_req_if u_req ();

    warmup_counter u_warmup (
        .Clk     (Clk),
        .Myreset (Myreset),
        .o_warm  (warm)
    );

    store_align u_store_align (
        .i_op    (i_req_op),
        .i_addr  (i_req_addr),
        .i_wdata (i_req_wdata),
        .req     (u_req.fmt)
    );

    load_extend u_load_extend (
        .i_op     (ld_op),
        .i_offset (ld_offset),
        .i_word   (ld_raw),
        .o_data   (ld_data)
    );

    bus_fsm u_bus_fsm (
        .Clk          (Clk),
        .Myreset      (Myreset),
        .i_warm       (warm),
        .i_req_valid  (i_req_valid),
        .req          (u_req.fsm),
        .o_req_ready  (o_req_ready),
        .o_op         (ld_op),
        .o_offset     (ld_offset),
        .o_raw_word   (ld_raw),
        .i_load_data  (ld_data),
        .o_resp_valid (o_resp_valid),
        .o_resp_rdata (o_resp_rdata),
        .o_resp_err   (o_resp_err),
        .o_araddr     (o_araddr),
        .o_arsize     (o_arsize),
        .o_arvalid    (o_arvalid),
        .i_arready    (i_arready),
        .i_rdata      (i_rdata),
        .i_rresp      (i_rresp),
        .i_rvalid     (i_rvalid),
        .o_rready     (o_rready),
        .o_awaddr     (o_awaddr),
        .o_awsize     (o_awsize),
        .o_awvalid    (o_awvalid),
        .i_awready    (i_awready),
        .o_wdata      (o_wdata),
        .o_wstrb      (o_wstrb),
        .o_wvalid     (o_wvalid),
        .i_wready     (i_wready),
        .i_bresp      (i_bresp),
        .i_bvalid     (i_bvalid),
        .o_bready     (o_bready)
    );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic Clk
);

    // 100 ns period
    initial begin
        Clk = 1'b0;
        forever begin
            #50 Clk = ~Clk;
        end
    end

endmodule

// ==== lsu_assert.sv ====
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_assert (
    input logic                    Clk,
    input logic                    Myreset,
    input lsu_pkg::bus_state_e     state,
    input logic                    o_arvalid,
    input logic                    i_arready,
    input logic [`LSU_ADDR_W-1:0]  o_araddr,
    input logic                    o_awvalid,
    input logic                    i_awready,
    input logic [`LSU_ADDR_W-1:0]  o_awaddr,
    input logic                    o_wvalid,
    input logic                    i_wready,
    input logic [`LSU_DATA_W-1:0]  o_wdata,
    input logic [`LSU_STRB_W-1:0]  o_wstrb,
    input logic                    o_resp_valid
);

    // Valid held with stable payload until ready
    ar_hold: assert property (@(posedge Clk) disable iff (Myreset)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr))
        else $error("arvalid dropped or araddr changed before arready");
    aw_hold: assert property (@(posedge Clk) disable iff (Myreset)
        o_awvalid && !i_awready |=> o_awvalid && $stable(o_awaddr))
        else $error("awvalid dropped or awaddr changed before awready");
    w_hold: assert property (@(posedge Clk) disable iff (Myreset)
        o_wvalid && !i_wready |=> o_wvalid && $stable(o_wdata) && $stable(o_wstrb))
        else $error("wvalid dropped or write payload changed before wready");

    ar_aw_excl: assert property (@(posedge Clk) disable iff (Myreset)
        !(o_arvalid && o_awvalid))
        else $error("arvalid and awvalid high together");
    resp_pulse: assert property (@(posedge Clk) disable iff (Myreset)
        o_resp_valid |=> !o_resp_valid)
        else $error("o_resp_valid high for two cycles");
    resp_idle: assert property (@(posedge Clk) disable iff (Myreset)
        o_resp_valid |=> state == lsu_pkg::ST_IDLE)
        else $error("FSM did not return to idle after the response");

endmodule

bind bus_fsm lsu_assert u_lsu_assert (
    .Clk          (Clk),
    .Myreset      (Myreset),
    .state        (state),
    .o_arvalid    (o_arvalid),
    .i_arready    (i_arready),
    .o_araddr     (o_araddr),
    .o_awvalid    (o_awvalid),
    .i_awready    (i_awready),
    .o_awaddr     (o_awaddr),
    .o_wvalid     (o_wvalid),
    .i_wready     (i_wready),
    .o_wdata      (o_wdata),
    .o_wstrb      (o_wstrb),
    .o_resp_valid (o_resp_valid)
);

// ==== lsu_tb.sv ====
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_tb;

    localparam int N_REQ = 88;
    localparam int LIMIT = N_REQ * 40 + 100;
    localparam logic [31:0] ERR_ADDR = 32'h0000_00F0;

    logic                    Clk;
    logic                    Myreset;
    logic                    i_req_valid;
    lsu_pkg::mem_op_e        i_req_op;
    logic [`LSU_ADDR_W-1:0]  i_req_addr;
    logic [`LSU_DATA_W-1:0]  i_req_wdata;
    logic                    o_req_ready;
    logic                    o_resp_valid;
    logic [`LSU_DATA_W-1:0]  o_resp_rdata;
    logic                    o_resp_err;
    logic [`LSU_ADDR_W-1:0]  o_araddr;
    logic [`LSU_SIZE_W-1:0]  o_arsize;
    logic                    o_arvalid;
    logic                    i_arready;
    logic [`LSU_DATA_W-1:0]  i_rdata;
    logic [1:0]              i_rresp;
    logic                    i_rvalid;
    logic                    o_rready;
    logic [`LSU_ADDR_W-1:0]  o_awaddr;
    logic [`LSU_SIZE_W-1:0]  o_awsize;
    logic                    o_awvalid;
    logic                    i_awready;
    logic [`LSU_DATA_W-1:0]  o_wdata;
    logic [`LSU_STRB_W-1:0]  o_wstrb;
    logic                    o_wvalid;
    logic                    i_wready;
    logic [1:0]              i_bresp;
    logic                    i_bvalid;
    logic                    o_bready;

    logic [31:0] mem [0:63];
    logic [33:0] exp_q [$];
    int          acc_q [$];
    int          lat_q [$];
    int          cyc = 0;
    int          errors = 0;
    int          issued = 0;
    int          resp_cnt = 0;
    int          chan_cnt = 0;
    integer      seed = 32'h7e34a323;
    logic [2:0]  exp_size = 3'd0;
    logic [31:0] exp_addr = 32'h0;

    tb_clk_gen u_clk (.Clk(Clk));

    lsu_top i_lsu_top (.*);

    // Expected {misaligned, err, data} from the opcode, address and memory
    function automatic logic [33:0] ref_access(input lsu_pkg::mem_op_e op,
                                               input logic [31:0] addr,
                                               input logic [31:0] m [0:63]);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        logic        mis;
        logic        err;
        w   = m[addr[7:2]];
        b   = 8'(w >> {addr[1:0], 3'b000});
        h   = addr[1] ? w[31:16] : w[15:0];
        mis = ((op == lsu_pkg::OP_LH || op == lsu_pkg::OP_LHU || op == lsu_pkg::OP_SH)
               && addr[0]) ||
              ((op == lsu_pkg::OP_LW || op == lsu_pkg::OP_SW) && addr[1:0] != 2'b00);
        err = mis || (addr[31:2] == ERR_ADDR[31:2]);
        if (err || op == lsu_pkg::OP_SB || op == lsu_pkg::OP_SH || op == lsu_pkg::OP_SW) begin
            return {mis, err, 32'h0};
        end
        case (op)
            lsu_pkg::OP_LB:  return {2'b00, {24{b[7]}}, b};
            lsu_pkg::OP_LBU: return {2'b00, 24'h0, b};
            lsu_pkg::OP_LH:  return {2'b00, {16{h[15]}}, h};
            lsu_pkg::OP_LHU: return {2'b00, 16'h0, h};
            default:         return {2'b00, w};
        endcase
    endfunction

    // Transfer size code, 0 byte, 1 half, 2 word
    function automatic logic [2:0] size_of(input lsu_pkg::mem_op_e op);
        case (op)
            lsu_pkg::OP_LB, lsu_pkg::OP_LBU, lsu_pkg::OP_SB: return 3'd0;
            lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: return 3'd1;
            default:                                         return 3'd2;
        endcase
    endfunction

    // Memory word after a good store
    function automatic logic [31:0] stored_word(input logic [31:0] old,
                                                input lsu_pkg::mem_op_e op,
                                                input logic [31:0] addr,
                                                input logic [31:0] wdata);
        logic [31:0] r;
        r = old;
        if (op == lsu_pkg::OP_SB) begin
            r[8*addr[1:0] +: 8] = wdata[7:0];
        end else if (op == lsu_pkg::OP_SH) begin
            r[16*addr[1] +: 16] = wdata[15:0];
        end else begin
            r = wdata;
        end
        return r;
    endfunction

    task automatic issue(input lsu_pkg::mem_op_e op, input logic [31:0] addr,
                         input logic [31:0] wdata);
        logic [33:0] exp;
        logic [31:0] exp_word;
        logic        is_st;
        int          chan_start;
        exp   = ref_access(op, addr, mem);
        is_st = (op == lsu_pkg::OP_SB || op == lsu_pkg::OP_SH || op == lsu_pkg::OP_SW);
        exp_word = exp[32] ? mem[addr[7:2]] : stored_word(mem[addr[7:2]], op, addr, wdata);
        exp_size = size_of(op);
        exp_addr = addr;
        @(posedge Clk);
        i_req_valid <= 1'b1;
        i_req_op    <= op;
        i_req_addr  <= addr;
        i_req_wdata <= wdata;
        @(negedge Clk);
        while (!o_req_ready) begin
            @(negedge Clk);
        end
        exp_q.push_back(exp);
        acc_q.push_back(cyc);
        lat_q.push_back(exp[33] ? 2 : 0);
        chan_start = chan_cnt;
        issued++;
        @(posedge Clk);
        i_req_valid <= 1'b0;
        while (resp_cnt < issued) begin
            @(negedge Clk);
        end
        if (exp[33]) begin
            assert (chan_cnt == chan_start) else begin
                $display("** Error at %0t: bus channel active for misaligned address %h",
                         $time, addr);
                errors++;
            end
        end
        if (is_st) begin
            assert (mem[addr[7:2]] === exp_word) else begin
                $display("** Error at %0t: memory word %0h is %h, expected %h",
                         $time, addr, mem[addr[7:2]], exp_word);
                errors++;
            end
        end
    endtask

    always @(posedge Clk) begin
        cyc <= cyc + 1;
        if (cyc == LIMIT) begin
            $display("Timeout: the run was stopped after %0d cycles", cyc);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    always @(negedge Clk) begin
        if (o_arvalid || o_awvalid || o_wvalid) begin
            chan_cnt++;
        end
    end

    // Compares each response with the queued expectation
    always @(negedge Clk) begin : compare
        logic [33:0] e;
        int          a;
        int          l;
        if (o_resp_valid) begin
            if (exp_q.size() == 0) begin
                $display("A response arrived with no request outstanding");
                errors++;
            end else begin
                e = exp_q.pop_front();
                a = acc_q.pop_front();
                l = lat_q.pop_front();
                assert (o_resp_err === e[32]) else begin
                    $display("** Error at %0t: o_resp_err %b, expected %b",
                             $time, o_resp_err, e[32]);
                    errors++;
                end
                assert (o_resp_rdata === e[31:0]) else begin
                    $display("** Error at %0t: o_resp_rdata %h, expected %h",
                             $time, o_resp_rdata, e[31:0]);
                    errors++;
                end
                if (l != 0) begin
                    assert (cyc - a == l) else begin
                        $display("** Error at %0t: response latency %0d, expected %0d",
                                 $time, cyc - a, l);
                        errors++;
                    end
                end
            end
            resp_cnt++;
        end
    end

    // Read slave
    initial begin : rd_slave
        int d;
        forever begin
            @(negedge Clk);
            if (o_arvalid) begin
                assert (o_arsize === exp_size && o_araddr === exp_addr) else begin
                    $display("** Error at %0t: ar size %0d addr %h, expected %0d %h",
                             $time, o_arsize, o_araddr, exp_size, exp_addr);
                    errors++;
                end
                d = $random(seed) & 3;
                @(posedge Clk);
                repeat (d) @(posedge Clk);
                i_arready <= 1'b1;
                @(posedge Clk);
                i_arready <= 1'b0;
                d = $random(seed) & 3;
                repeat (d) @(posedge Clk);
                i_rvalid <= 1'b1;
                i_rdata  <= mem[o_araddr[7:2]];
                i_rresp  <= (o_araddr[31:2] == ERR_ADDR[31:2]) ? 2'b10 : 2'b00;
                @(negedge Clk);
                assert (o_rready) else begin
                    $display("** Error at %0t: o_rready low during the read data beat",
                             $time);
                    errors++;
                end
                @(posedge Clk);
                i_rvalid <= 1'b0;
                i_rresp  <= 2'b00;
            end
        end
    end

    // Write slave, aw and w readies delayed independently
    initial begin : wr_slave
        int          da;
        int          dw;
        int          db;
        logic [31:0] waddr;
        logic [31:0] wdat;
        logic [3:0]  strb;
        forever begin
            @(negedge Clk);
            if (o_awvalid || o_wvalid) begin
                assert (o_awsize === exp_size && o_awaddr === exp_addr) else begin
                    $display("** Error at %0t: aw size %0d addr %h, expected %0d %h",
                             $time, o_awsize, o_awaddr, exp_size, exp_addr);
                    errors++;
                end
                da    = $random(seed) & 3;
                dw    = $random(seed) & 3;
                db    = $random(seed) & 3;
                waddr = o_awaddr;
                wdat  = o_wdata;
                strb  = o_wstrb;
                fork
                    begin
                        @(posedge Clk);
                        repeat (da) @(posedge Clk);
                        i_awready <= 1'b1;
                        @(posedge Clk);
                        i_awready <= 1'b0;
                    end
                    begin
                        @(posedge Clk);
                        repeat (dw) @(posedge Clk);
                        i_wready <= 1'b1;
                        @(posedge Clk);
                        i_wready <= 1'b0;
                    end
                join
                if (waddr[31:2] != ERR_ADDR[31:2]) begin
                    for (int i = 0; i < 4; i++) begin
                        if (strb[i]) begin
                            mem[waddr[7:2]][8*i +: 8] = wdat[8*i +: 8];
                        end
                    end
                end
                repeat (db) @(posedge Clk);
                i_bvalid <= 1'b1;
                i_bresp  <= (waddr[31:2] == ERR_ADDR[31:2]) ? 2'b10 : 2'b00;
                @(negedge Clk);
                assert (o_bready) else begin
                    $display("** Error at %0t: o_bready low during the write response",
                             $time);
                    errors++;
                end
                @(posedge Clk);
                i_bvalid <= 1'b0;
                i_bresp  <= 2'b00;
            end
        end
    end

    initial begin : main
        int          n;
        logic [31:0] a;
        Myreset     = 1'b1;
        i_req_valid = 1'b0;
        i_req_op    = lsu_pkg::OP_LW;
        i_req_addr  = '0;
        i_req_wdata = '0;
        i_arready   = 1'b0;
        i_rdata     = '0;
        i_rresp     = 2'b00;
        i_rvalid    = 1'b0;
        i_awready   = 1'b0;
        i_wready    = 1'b0;
        i_bresp     = 2'b00;
        i_bvalid    = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = {8'(i), 8'(~i), 8'(i * 3), 8'(i ^ 8'h5a)};
        end

        repeat (5) begin
            @(negedge Clk);
            assert (!o_req_ready) else begin
                $display("** Error at %0t: o_req_ready high during reset", $time);
                errors++;
            end
        end
        @(posedge Clk);
        Myreset <= 1'b0;
        n = 0;
        @(negedge Clk);
        while (!o_req_ready && n < 40) begin
            n++;
            @(negedge Clk);
        end
        assert (n == 16) else begin
            $display("** Error at %0t: ready after %0d warm-up cycles, expected 16", $time, n);
            errors++;
        end

        for (int k = 0; k < 4; k++) begin
            issue(lsu_pkg::OP_SW, 32'h40 + 4 * k, $random(seed));
            issue(lsu_pkg::OP_LW, 32'h40 + 4 * k, 32'h0);
        end

        // Sub-word stores then every load kind at every offset
        for (int k = 0; k < 4; k++) begin
            issue(lsu_pkg::OP_SB, 32'h20 + k, $random(seed));
        end
        issue(lsu_pkg::OP_SH, 32'h24, $random(seed));
        issue(lsu_pkg::OP_SH, 32'h26, $random(seed));
        for (int w = 0; w < 2; w++) begin
            for (int k = 0; k < 4; k++) begin
                a = 32'h20 + 4 * w + k;
                issue(lsu_pkg::OP_LB, a, 32'h0);
                issue(lsu_pkg::OP_LBU, a, 32'h0);
                if (k % 2 == 0) begin
                    issue(lsu_pkg::OP_LH, a, 32'h0);
                    issue(lsu_pkg::OP_LHU, a, 32'h0);
                end
                if (k == 0) begin
                    issue(lsu_pkg::OP_LW, a, 32'h0);
                end
            end
        end

        issue(lsu_pkg::OP_LH, 32'h31, 32'h0);
        issue(lsu_pkg::OP_LHU, 32'h33, 32'h0);
        issue(lsu_pkg::OP_SH, 32'h35, $random(seed));
        issue(lsu_pkg::OP_LW, 32'h36, 32'h0);
        issue(lsu_pkg::OP_SW, 32'h39, $random(seed));

        repeat (40) begin
            issue(lsu_pkg::mem_op_e'($random(seed) & 7), 32'($random(seed)) & 32'hFF,
                  $random(seed));
        end

        issue(lsu_pkg::OP_LW, ERR_ADDR, 32'h0);
        issue(lsu_pkg::OP_SW, ERR_ADDR, 32'h1234_5678);
        issue(lsu_pkg::OP_LB, ERR_ADDR + 1, 32'h0);

        @(negedge Clk);
        $display("Requests %0d, responses %0d, errors %0d", issued, resp_cnt, errors);
        if (errors == 0 && resp_cnt == issued) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+.
lsu_pkg.sv
mem_req_if.sv
warmup_counter.sv
store_align.sv
load_extend.sv
bus_fsm.sv
lsu_top.sv
tb_clk_gen.sv
lsu_assert.sv
lsu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module lsu_tb -o sim_lsu
./obj_dir/sim_lsu > sim.log 2>&1
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
exit 0
